//--- hdc_stimulus.txt
# name op args: write adr sel data | read adr expected | feat fix|rnd level
# run lanes last expected | busy lanes last lanes2 last2 expected, model = model only
rst_status  read  1 00000000
rst_result  read  5 00000000
rst_ctrl    read  0 00000000
id_wr       write 2 f 13579bdf
id_rd       read  2 13579bdf
lb_wr       write 3 f a5a55a5a
lb_rd       read  3 a5a55a5a
seed_wr     write 4 f ace1ace1
seed_byte   write 4 2 0000ff00
seed_rd     read  4 ace1ffe1
maj_feat    feat  fix 3
maj_run     run   0 1 5a5aa59a
maj_clear   read  1 00000000
part_id     write 2 f 0000001f
part_lv0    write 8 f fff00000
part_lv1    write 9 f ffffffff
part_lv2    write a f ffffffff
part_lv3    write b f ffffffff
part_run    run   5 1 a5a55a26
acc_id      write 2 f 13579bdf
acc_f1      feat  fix 0
acc_b1      run   0 0 00000000
acc_f2      feat  fix 4
acc_b2      run   0 0 00000000
acc_b3      run   0 0 00000000
acc_f4      feat  fix 8
acc_b4      run   0 1 5a5aa55a
acc_new     run   0 1 5a5a5a5a
tie_id      write 2 f 0000ffff
tie_seed    write 4 f ace1ace1
tie_feat    feat  fix 5
tie_b1      run   0 0 00000000
tie_b2      run   0 1 d650d673
busy_id     write 2 f 13579bdf
busy_feat   feat  fix 3
busy_cmd    busy  0 1 5 1 5a5aa59a
busy_ctrl   read  0 00000002
rnd_feat    feat  rnd 0
rnd_full    run   0 1 model
rnd_part    run   7 1 model

//--- filelist.f
+incdir+.
hdc_pkg.sv
wb_pkg.sv
wb_regs.sv
encode_seq.sv
bind_unit.sv
bundle_counter.sv
bundle_ctrl.sv
hdc_encoder_top.sv
tb_clock.sv
tb_hdc.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_hdc -f filelist.f -o sim_hdc
./obj_dir/sim_hdc | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "testbench did not pass, see sim.log"
exit 1

//--- tb_hdc.sv
`include "hdc_macros.svh"

module tb_hdc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLES_PER_LINE = 200;
    localparam int POLL_LIMIT = 40;
    localparam int ACK_LIMIT = 20;

    logic             clk;
    logic             reset;
    wb_pkg::wb_req_t  wb_req;
    wb_pkg::wb_rsp_t  wb_rsp;

    int     errors = 0;
    int     checks = 0;
    int     rng_seed = 73;
    int     watchdog_cycles = 0;
    string  lines [$];

    // reference model state
    hdc_pkg::hv_t  m_id;
    hdc_pkg::hv_t  m_lb;
    hdc_pkg::hv_t  m_seed;
    hdc_pkg::hv_t  m_lfsr;
    hdc_pkg::hv_t  m_result;
    hdc_pkg::hv_t  m_levels [4];
    int            m_cnt [32];
    bit            m_restart;

    tb_clock u_clock (
        .clk (clk)
    );

    hdc_encoder_top dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    task automatic check_value(input string name, input hdc_pkg::hv_t expected,
                               input hdc_pkg::hv_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // one classic transfer from falling edge to falling edge
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [3:0] sel,
                             input hdc_pkg::hv_t wdata, output hdc_pkg::hv_t rdata);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.dat = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        assert (wb_rsp.ack) else begin
            errors++;
            $display("ERROR: no ack from the bus slave at word address %0d", adr);
        end
        rdata = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic write_word(input logic [3:0] adr, input logic [3:0] sel,
                              input hdc_pkg::hv_t data);
        hdc_pkg::hv_t unused;
        bus_cycle(1'b1, adr, sel, data, unused);
    endtask

    task automatic read_word(input logic [3:0] adr, output hdc_pkg::hv_t data);
        bus_cycle(1'b0, adr, 4'hf, '0, data);
    endtask

    // each select bit takes one byte lane of the new word
    function automatic hdc_pkg::hv_t byte_merge(input hdc_pkg::hv_t old_word,
                                                input hdc_pkg::hv_t new_word,
                                                input logic [3:0] sel);
        hdc_pkg::hv_t take;
        take = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (new_word & take) | (old_word & ~take);
    endfunction

    function automatic hdc_pkg::hv_t lfsr_step(input hdc_pkg::hv_t state);
        hdc_pkg::hv_t next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // identity rotated by lane xor level base with 2*level low bits flipped
    function automatic hdc_pkg::hv_t bind_word(input int k);
        hdc_pkg::hv_t rot;
        hdc_pkg::hv_t flip;
        int level;
        level = int'(m_levels[k / 8][4 * (k % 8) +: 4]);
        rot = (k == 0) ? m_id : ((m_id << k) | (m_id >> (32 - k)));
        flip = '0;
        for (int b = 0; b < 2 * level; b++) begin
            flip[b] = 1'b1;
        end
        return rot ^ m_lb ^ flip;
    endfunction

    task automatic model_write(input logic [3:0] adr, input logic [3:0] sel,
                               input hdc_pkg::hv_t data);
        case (adr)
            `HDC_REG_ID_BASE: m_id = byte_merge(m_id, data, sel);
            `HDC_REG_LEVEL_BASE: m_lb = byte_merge(m_lb, data, sel);
            `HDC_REG_SEED: begin
                m_seed = byte_merge(m_seed, data, sel);
                m_lfsr = m_seed;
            end
            default: begin
                if (adr >= `HDC_REG_LEVELS0 && adr <= `HDC_REG_LEVELS3) begin
                    m_levels[adr - `HDC_REG_LEVELS0] =
                        byte_merge(m_levels[adr - `HDC_REG_LEVELS0], data, sel);
                end
            end
        endcase
    endtask

    task automatic apply_batch(input int lanes, input int last);
        hdc_pkg::hv_t words [32];
        hdc_pkg::hv_t tie;
        int n;
        int delta;
        n = (lanes == 0) ? 32 : lanes;
        tie = m_lfsr;
        m_lfsr = lfsr_step(m_lfsr);
        for (int k = 0; k < n; k++) begin
            words[k] = bind_word(k);
        end
        for (int i = 0; i < 32; i++) begin
            delta = 0;
            for (int k = 0; k < n; k++) begin
                delta += words[k][i] ? 1 : -1;
            end
            m_cnt[i] = m_restart ? delta : m_cnt[i] + delta;
        end
        m_restart = (last != 0);
        if (last != 0) begin
            for (int i = 0; i < 32; i++) begin
                m_result[i] = (m_cnt[i] > 0) ? 1'b1 : (m_cnt[i] < 0) ? 1'b0 : tie[i];
            end
        end
    endtask

    function automatic hdc_pkg::hv_t ctrl_word(input int lanes, input int last);
        return (hdc_pkg::hv_t'(lanes[4:0]) << 8) | (hdc_pkg::hv_t'(last[0]) << 1) | 32'h1;
    endfunction

    // poll STATUS until the sticky done flag shows up
    task automatic wait_done(input string name);
        hdc_pkg::hv_t status;
        int polls;
        status = '0;
        polls = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            read_word(`HDC_REG_STATUS, status);
            polls++;
        end
        assert (status[1]) else begin
            errors++;
            $display("ERROR: %s never reported done after the update command", name);
        end
        if (status[1]) begin
            check_value({name, "_status"}, 32'h2, status);
        end
    endtask

    task automatic compare_result(input string name, input string expect_str);
        hdc_pkg::hv_t rdata;
        hdc_pkg::hv_t listed;
        int count;
        read_word(`HDC_REG_RESULT, rdata);
        check_value({name, "_model"}, m_result, rdata);
        if (expect_str != "model") begin
            count = $sscanf(expect_str, "%h", listed);
            check_value({name, "_file"}, listed, rdata);
        end
    endtask

    task automatic run_batch(input string name, input int lanes, input int last,
                             input string expect_str);
        write_word(`HDC_REG_CTRL, 4'hf, ctrl_word(lanes, last));
        wait_done(name);
        apply_batch(lanes, last);
        if (last != 0) begin
            compare_result(name, expect_str);
        end
    endtask

    // second command lands while the first batch is in flight
    task automatic busy_batch(input string name, input int lanes, input int last,
                              input int lanes2, input int last2, input string expect_str);
        write_word(`HDC_REG_CTRL, 4'hf, ctrl_word(lanes, last));
        write_word(`HDC_REG_CTRL, 4'hf, ctrl_word(lanes2, last2));
        wait_done(name);
        apply_batch(lanes, last);
        if (last != 0) begin
            compare_result(name, expect_str);
        end
    endtask

    task automatic load_levels(input string mode, input int level);
        hdc_pkg::hv_t word;
        logic [3:0] nib;
        nib = level[3:0];
        for (int n = 0; n < 4; n++) begin
            if (mode == "rnd") begin
                word = $random(rng_seed);
            end else begin
                word = {8{nib}};
            end
            write_word(4'(`HDC_REG_LEVELS0 + n), 4'hf, word);
            model_write(4'(`HDC_REG_LEVELS0 + n), 4'hf, word);
        end
    endtask

    initial begin
        string line;
        string name;
        string op;
        string arg;
        int fd;
        int count;
        int a;
        int b;
        int c;
        int d;
        hdc_pkg::hv_t value;
        hdc_pkg::hv_t rdata;
        wb_req = '0;
        reset = 1'b1;
        m_id = '0;
        m_lb = '0;
        m_seed = '0;
        m_lfsr = 32'h1;
        m_result = '0;
        m_restart = 1'b0;
        for (int n = 0; n < 4; n++) begin
            m_levels[n] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            m_cnt[i] = 0;
        end
        fd = $fopen("hdc_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open the stimulus file hdc_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        watchdog_cycles = (lines.size() + 1) * CYCLES_PER_LINE;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        foreach (lines[i]) begin
            count = $sscanf(lines[i], "%s %s", name, op);
            if (op == "write") begin
                count = $sscanf(lines[i], "%s %s %h %h %h", name, op, a, b, value);
                write_word(4'(a), 4'(b), value);
                model_write(4'(a), 4'(b), value);
            end else if (op == "read") begin
                count = $sscanf(lines[i], "%s %s %h %h", name, op, a, value);
                read_word(4'(a), rdata);
                check_value(name, value, rdata);
            end else if (op == "feat") begin
                count = $sscanf(lines[i], "%s %s %s %h", name, op, arg, a);
                load_levels(arg, a);
            end else if (op == "run") begin
                count = $sscanf(lines[i], "%s %s %d %d %s", name, op, a, b, arg);
                run_batch(name, a, b, arg);
            end else if (op == "busy") begin
                count = $sscanf(lines[i], "%s %s %d %d %d %d %s", name, op, a, b, c, d, arg);
                busy_batch(name, a, b, c, d, arg);
            end else begin
                errors++;
                $display("ERROR: unknown operation %s on stimulus line %0d", op, i);
            end
        end

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog sized from the stimulus length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles before the stimulus finished",
                 watchdog_cycles);
        $display("checks run %0d, errors %0d", checks, errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    localparam real HALF_PERIOD = 5.0;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- hdc_encoder_top.sv
`include "hdc_macros.svh"

module hdc_encoder_top (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::wb_req_t  wb_req,
    output wb_pkg::wb_rsp_t  wb_rsp
);

    hdc_pkg::hv_t     id_base;
    hdc_pkg::hv_t     level_base;
    hdc_pkg::hv_t     seed;
    hdc_pkg::hv_t     result;
    hdc_pkg::hv_t     tie_word;
    hdc_pkg::level_t  levels [`HDC_LANES];
    hdc_pkg::hv_t     bound [`HDC_LANES];
    hdc_pkg::lanes_t  reg_lanes;
    hdc_pkg::lanes_t  batch_lanes;
    logic             cmd_update;
    logic             cmd_last;
    logic             seed_load;
    logic             busy;
    logic             done;
    logic             bind_en;
    logic             update;
    logic             last_update;
    logic             get_fin;
    logic             stream_v;

    wb_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .id_base    (id_base),
        .level_base (level_base),
        .levels     (levels),
        .lanes      (reg_lanes),
        .cmd_update (cmd_update),
        .cmd_last   (cmd_last),
        .seed_load  (seed_load),
        .seed       (seed)
    );

    encode_seq u_seq (
        .clk         (clk),
        .reset       (reset),
        .cmd_update  (cmd_update),
        .cmd_last    (cmd_last),
        .seed_load   (seed_load),
        .seed        (seed),
        .lanes_in    (reg_lanes),
        .bind_en     (bind_en),
        .update      (update),
        .last_update (last_update),
        .get_fin     (get_fin),
        .stream_v    (stream_v),
        .lanes       (batch_lanes),
        .tie_word    (tie_word),
        .busy        (busy),
        .done        (done)
    );

    bind_unit u_bind (
        .clk        (clk),
        .reset      (reset),
        .bind_en    (bind_en),
        .id_base    (id_base),
        .level_base (level_base),
        .levels     (levels),
        .bound      (bound)
    );

    bundle_ctrl u_bundle (
        .clk         (clk),
        .reset       (reset),
        .bound       (bound),
        .lanes       (batch_lanes),
        .tie_word    (tie_word),
        .update      (update),
        .last_update (last_update),
        .get_fin     (get_fin),
        .stream_v    (stream_v),
        .result      (result)
    );

endmodule

//--- bundle_ctrl.sv
`include "hdc_macros.svh"

module bundle_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  hdc_pkg::hv_t     bound [`HDC_LANES],
    input  hdc_pkg::lanes_t  lanes,
    input  hdc_pkg::hv_t     tie_word,
    input  logic             update,
    input  logic             last_update,
    input  logic             get_fin,
    input  logic             stream_v,
    output hdc_pkg::hv_t     result
);

    hdc_pkg::hv_t  signs;
    logic          fin_q;

    for (genvar i = 0; i < `HDC_HV_WIDTH; i++) begin : g_bit
        hdc_pkg::lane_bits_t  lane_bits;

        // bit i of every bound word
        for (genvar k = 0; k < `HDC_LANES; k++) begin : g_tr
            assign lane_bits[k] = bound[k][i];
        end

        bundle_counter u_counter (
            .clk         (clk),
            .reset       (reset),
            .votes       (lane_bits),
            .lanes       (lanes),
            .tie_bit     (tie_word[i]),
            .update      (update),
            .last_update (last_update),
            .sign_bit    (signs[i])
        );
    end

    // signs are final one cycle after get_fin
    always_ff @(posedge clk) begin
        if (reset) begin
            fin_q <= 1'b0;
            result <= '0;
        end else begin
            if (get_fin) begin
                fin_q <= 1'b1;
            end else if (stream_v) begin
                fin_q <= 1'b0;
            end
            if (stream_v && fin_q) begin
                result <= signs;
            end
        end
    end

endmodule

//--- bundle_counter.sv
`include "hdc_macros.svh"

module bundle_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  hdc_pkg::lane_bits_t  votes,
    input  hdc_pkg::lanes_t      lanes,
    input  logic                 tie_bit,
    input  logic                 update,
    input  logic                 last_update,
    output logic                 sign_bit
);

    hdc_pkg::vote_t      count;
    hdc_pkg::vote_t      delta;
    hdc_pkg::lane_bits_t active;
    logic                restart;
    logic                tie_q;

    // lanes of zero means every lane votes
    assign active = (lanes == '0) ? '1 : (hdc_pkg::lane_bits_t'(1) << lanes) - 1'b1;

    // ones count up, zeros count down
    always_comb begin
        delta = '0;
        for (int i = 0; i < `HDC_LANES; i++) begin
            if (active[i]) begin
                delta = votes[i] ? delta + hdc_pkg::vote_t'(1) : delta - hdc_pkg::vote_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            restart <= 1'b0;
            tie_q <= 1'b0;
        end else if (update) begin
            // first batch of a new sample drops the old total
            count <= restart ? delta : count + delta;
            restart <= last_update;
            if (last_update) begin
                tie_q <= tie_bit;
            end
        end
    end

    assign sign_bit = (count > 0) ? 1'b1 : (count < 0) ? 1'b0 : tie_q;

endmodule

//--- bind_unit.sv
`include "hdc_macros.svh"

module bind_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             bind_en,
    input  hdc_pkg::hv_t     id_base,
    input  hdc_pkg::hv_t     level_base,
    input  hdc_pkg::level_t  levels [`HDC_LANES],
    output hdc_pkg::hv_t     bound [`HDC_LANES]
);

    hdc_pkg::hv_t  bound_next [`HDC_LANES];

    for (genvar k = 0; k < `HDC_LANES; k++) begin : g_lane
        hdc_pkg::hv_t  id_rot;
        hdc_pkg::hv_t  flip_mask;
        logic [2*`HDC_HV_WIDTH-1:0] id_twice;

        // rotate left by lane index
        assign id_twice = {id_base, id_base} << k;
        assign id_rot = id_twice[2*`HDC_HV_WIDTH-1:`HDC_HV_WIDTH];

        // level walks away from the base two bits per step
        assign flip_mask = (hdc_pkg::hv_t'(1) << {levels[k], 1'b0}) - hdc_pkg::hv_t'(1);

        assign bound_next[k] = id_rot ^ level_base ^ flip_mask;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `HDC_LANES; k++) begin
                bound[k] <= '0;
            end
        end else if (bind_en) begin
            for (int k = 0; k < `HDC_LANES; k++) begin
                bound[k] <= bound_next[k];
            end
        end
    end

endmodule

//--- encode_seq.sv
`include "hdc_macros.svh"

module encode_seq (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_update,
    input  logic             cmd_last,
    input  logic             seed_load,
    input  hdc_pkg::hv_t     seed,
    input  hdc_pkg::lanes_t  lanes_in,
    output logic             bind_en,
    output logic             update,
    output logic             last_update,
    output logic             get_fin,
    output logic             stream_v,
    output hdc_pkg::lanes_t  lanes,
    output hdc_pkg::hv_t     tie_word,
    output logic             busy,
    output logic             done
);

    hdc_pkg::seq_state_t  state;
    hdc_pkg::lanes_t      lanes_q;
    logic                 last_q;
    logic                 done_q;
    hdc_pkg::hv_t         lfsr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hdc_pkg::IDLE;
            lanes_q <= '0;
            last_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                hdc_pkg::IDLE: begin
                    // batch parameters frozen for the whole pass
                    if (cmd_update) begin
                        lanes_q <= lanes_in;
                        last_q <= cmd_last;
                        state <= hdc_pkg::BIND;
                    end
                end
                hdc_pkg::BIND: begin
                    state <= hdc_pkg::ACCUM;
                end
                hdc_pkg::ACCUM: begin
                    if (last_q) begin
                        state <= hdc_pkg::FIN;
                    end else begin
                        state <= hdc_pkg::IDLE;
                        done_q <= 1'b1;
                    end
                end
                hdc_pkg::FIN: begin
                    state <= hdc_pkg::CAPTURE;
                end
                hdc_pkg::CAPTURE: begin
                    state <= hdc_pkg::IDLE;
                    done_q <= 1'b1;
                end
                default: begin
                    state <= hdc_pkg::IDLE;
                end
            endcase
        end
    end

    // one lfsr step per update, counters see the pre-step word
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= hdc_pkg::hv_t'(1);
        end else if (seed_load) begin
            lfsr <= seed;
        end else if (state == hdc_pkg::ACCUM) begin
            lfsr <= (lfsr >> 1) ^ (lfsr[0] ? `HDC_LFSR_TAPS : '0);
        end
    end

    assign bind_en = (state == hdc_pkg::BIND);
    assign update = (state == hdc_pkg::ACCUM);
    assign last_update = update && last_q;
    assign get_fin = (state == hdc_pkg::FIN);
    assign stream_v = (state == hdc_pkg::CAPTURE);
    assign busy = (state != hdc_pkg::IDLE);
    assign done = done_q;
    assign lanes = lanes_q;
    assign tie_word = lfsr;

endmodule

//--- wb_regs.sv
`include "hdc_macros.svh"

module wb_regs (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::wb_req_t  wb_req,
    output wb_pkg::wb_rsp_t  wb_rsp,
    input  logic             busy,
    input  logic             done,
    input  hdc_pkg::hv_t     result,
    output hdc_pkg::hv_t     id_base,
    output hdc_pkg::hv_t     level_base,
    output hdc_pkg::level_t  levels [`HDC_LANES],
    output hdc_pkg::lanes_t  lanes,
    output logic             cmd_update,
    output logic             cmd_last,
    output logic             seed_load,
    output hdc_pkg::hv_t     seed
);

    localparam int NIB_PER_WORD = `HDC_HV_WIDTH / `HDC_LEVEL_WIDTH;

    logic            ack_q;
    hdc_pkg::hv_t    rdata_q;
    logic            done_flag;
    hdc_pkg::hv_t    level_regs [`HDC_LANES / NIB_PER_WORD];
    hdc_pkg::hv_t    ctrl_rd;
    hdc_pkg::hv_t    ctrl_wr;
    hdc_pkg::hv_t    rd_word;
    logic            req_valid;
    logic            wr;
    logic            rd;

    function automatic hdc_pkg::hv_t merge_bytes(input hdc_pkg::hv_t old_word,
                                                 input hdc_pkg::hv_t new_word,
                                                 input logic [3:0] sel);
        hdc_pkg::hv_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // one request per ack, no back-to-back sampling
    assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr = req_valid && wb_req.we;
    assign rd = req_valid && !wb_req.we;

    // ctrl readback, command bit always reads 0
    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[1] = cmd_last;
        ctrl_rd[12:8] = lanes;
    end
    assign ctrl_wr = merge_bytes(ctrl_rd, wb_req.dat, wb_req.sel);

    always_comb begin
        case (wb_req.adr)
            `HDC_REG_CTRL:       rd_word = ctrl_rd;
            `HDC_REG_STATUS:     rd_word = {30'b0, done_flag, busy};
            `HDC_REG_ID_BASE:    rd_word = id_base;
            `HDC_REG_LEVEL_BASE: rd_word = level_base;
            `HDC_REG_SEED:       rd_word = seed;
            `HDC_REG_RESULT:     rd_word = result;
            `HDC_REG_LEVELS0:    rd_word = level_regs[0];
            `HDC_REG_LEVELS1:    rd_word = level_regs[1];
            `HDC_REG_LEVELS2:    rd_word = level_regs[2];
            `HDC_REG_LEVELS3:    rd_word = level_regs[3];
            default:             rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            rdata_q <= '0;
            done_flag <= 1'b0;
            cmd_update <= 1'b0;
            cmd_last <= 1'b0;
            lanes <= '0;
            seed_load <= 1'b0;
            seed <= '0;
            id_base <= '0;
            level_base <= '0;
            for (int n = 0; n < `HDC_LANES / NIB_PER_WORD; n++) begin
                level_regs[n] <= '0;
            end
        end else begin
            ack_q <= req_valid;
            cmd_update <= 1'b0;
            seed_load <= 1'b0;
            if (rd) begin
                rdata_q <= rd_word;
            end
            // sticky done, a new done wins over the clearing read
            if (done) begin
                done_flag <= 1'b1;
            end else if (rd && wb_req.adr == `HDC_REG_STATUS) begin
                done_flag <= 1'b0;
            end
            if (wr) begin
                case (wb_req.adr)
                    `HDC_REG_CTRL: begin
                        // whole write dropped while a batch is in flight
                        if (!busy) begin
                            cmd_update <= ctrl_wr[0];
                            cmd_last <= ctrl_wr[1];
                            lanes <= ctrl_wr[12:8];
                        end
                    end
                    `HDC_REG_ID_BASE: begin
                        id_base <= merge_bytes(id_base, wb_req.dat, wb_req.sel);
                    end
                    `HDC_REG_LEVEL_BASE: begin
                        level_base <= merge_bytes(level_base, wb_req.dat, wb_req.sel);
                    end
                    `HDC_REG_SEED: begin
                        seed <= merge_bytes(seed, wb_req.dat, wb_req.sel);
                        seed_load <= 1'b1;
                    end
                    `HDC_REG_LEVELS0: begin
                        level_regs[0] <= merge_bytes(level_regs[0], wb_req.dat, wb_req.sel);
                    end
                    `HDC_REG_LEVELS1: begin
                        level_regs[1] <= merge_bytes(level_regs[1], wb_req.dat, wb_req.sel);
                    end
                    `HDC_REG_LEVELS2: begin
                        level_regs[2] <= merge_bytes(level_regs[2], wb_req.dat, wb_req.sel);
                    end
                    `HDC_REG_LEVELS3: begin
                        level_regs[3] <= merge_bytes(level_regs[3], wb_req.dat, wb_req.sel);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // lane 8n+j sits in nibble j of LEVELS n
    for (genvar k = 0; k < `HDC_LANES; k++) begin : g_levels
        assign levels[k] =
            level_regs[k / NIB_PER_WORD][(k % NIB_PER_WORD) * `HDC_LEVEL_WIDTH +: `HDC_LEVEL_WIDTH];
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;

endmodule

//--- wb_pkg.sv
`include "hdc_macros.svh"

package wb_pkg;

    // master to slave, classic single transfers
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        logic [`HDC_WB_ADR_WIDTH-1:0]   adr;
        logic [`HDC_WB_DAT_WIDTH-1:0]   dat;
        logic [`HDC_WB_DAT_WIDTH/8-1:0] sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                           ack;
        logic [`HDC_WB_DAT_WIDTH-1:0]   dat;
    } wb_rsp_t;

endpackage

//--- hdc_pkg.sv
`include "hdc_macros.svh"

package hdc_pkg;

    // one hypervector word
    typedef logic [`HDC_HV_WIDTH-1:0] hv_t;

    // quantized feature level
    typedef logic [`HDC_LEVEL_WIDTH-1:0] level_t;

    // active lane count, zero selects all lanes
    typedef logic [$clog2(`HDC_LANES)-1:0] lanes_t;

    // per-bit signed vote accumulator
    typedef logic signed [`HDC_COUNT_WIDTH-1:0] vote_t;

    // one vote bit from every lane
    typedef logic [`HDC_LANES-1:0] lane_bits_t;

    // batch sequencer states
    //   BIND     bound words registered
    //   ACCUM    votes applied to counters
    //   FIN      counters settled
    //   CAPTURE  sign word into result
    typedef enum logic [2:0] {
        IDLE,
        BIND,
        ACCUM,
        FIN,
        CAPTURE
    } seq_state_t;

endpackage

//--- hdc_macros.svh
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// hypervector chunk and feature geometry
`define HDC_HV_WIDTH      32
`define HDC_LANES         32
`define HDC_LEVEL_WIDTH   4
// signed vote counter, enough for 8 full batches
`define HDC_COUNT_WIDTH   10

// tie-break lfsr, galois right shift
`define HDC_LFSR_TAPS     32'h8020_0003

// wishbone geometry
`define HDC_WB_ADR_WIDTH  4
`define HDC_WB_DAT_WIDTH  32

// register word offsets
`define HDC_REG_CTRL       4'd0
`define HDC_REG_STATUS     4'd1
`define HDC_REG_ID_BASE    4'd2
`define HDC_REG_LEVEL_BASE 4'd3
`define HDC_REG_SEED       4'd4
`define HDC_REG_RESULT     4'd5
`define HDC_REG_LEVELS0    4'd8
`define HDC_REG_LEVELS1    4'd9
`define HDC_REG_LEVELS2    4'd10
`define HDC_REG_LEVELS3    4'd11

`endif
